/* flist.f */
common/trig_delay_pkg.sv
common/trig_cfg_if.sv
cmd_fsm/cmd_fsm.sv
rtl/trigger_sync.sv
rtl/arm_control.sv
rtl/delay_timer.sv
rtl/trig_delay_top.sv
verification/tb_trig_delay_asserts.sv
verification/tb_trig_delay.sv

/* Makefile */
# Verilator build and run for the trigger delay unit testbench

VERILATOR ?= verilator
TOP       ?= tb_trig_delay
BUILD_DIR ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

/* verification/tb_trig_delay.sv */
module tb_trig_delay import trig_delay_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int N_READBACK = 8;
    localparam int N_TIMING   = 6;
    localparam int N_SINGLE   = 3;
    localparam int SET_CYC    = 5;                  // Command byte plus payload
    localparam int GET_CYC    = 1 + 4 * 16;         // Up to 16 stall cycles per byte
    localparam int TRIG_CYC   = 4 + 40 + 20 + 12;   // Trigger, longest delay and width
    localparam int PHASE_CYC  = 8 + 3 * GET_CYC + 2 * TRIG_CYC
                              + N_READBACK * (2 * SET_CYC + 2 * GET_CYC)
                              + 2 * N_TIMING * (2 * SET_CYC + TRIG_CYC) + 4 * SET_CYC
                              + N_SINGLE * (4 * SET_CYC + GET_CYC + 2 * TRIG_CYC)
                              + 8 * SET_CYC + 3 * GET_CYC + 2 * TRIG_CYC;
    localparam int TIMEOUT_CYCLES = 2 * PHASE_CYC;

    logic              clk_sys_buf;
    logic              rst_sync;
    logic              trigger_in;
    logic [BYTE_W-1:0] cmd_data;
    logic              cmd_valid;
    logic [BYTE_W-1:0] resp_data;
    logic              resp_valid;
    logic              resp_ready;
    logic              trigger_delayed_out;

    int          cycle = 0;           // Number of the last rising edge
    logic [31:0] rng_state = 32'd99;
    logic [31:0] delay_m;             // Model of the DUT configuration
    logic [31:0] width_m;
    logic        armed_m;
    trig_mode_e  trig_mode_m;
    armed_mode_e armed_mode_m;

    trig_delay_top #(
        .DELAY_W             (CFG_W),
        .SYNC_STAGES         (3)
    ) dut_i (
        .clk_sys_buf         (clk_sys_buf),
        .rst_sync            (rst_sync),
        .trigger_in          (trigger_in),
        .cmd_data            (cmd_data),
        .cmd_valid           (cmd_valid),
        .resp_data           (resp_data),
        .resp_valid          (resp_valid),
        .resp_ready          (resp_ready),
        .trigger_delayed_out (trigger_delayed_out)
    );

    bind delay_timer tb_trig_delay_asserts timer_asserts_i (
        .clk_sys_buf (clk_sys_buf), .rst_sync (rst_sync), .fire (fire),
        .trigger_delayed_out (trigger_delayed_out),
        .resp_data (8'h00), .resp_valid (1'b0), .resp_ready (1'b0)
    );

    bind cmd_fsm tb_trig_delay_asserts resp_asserts_i (
        .clk_sys_buf (clk_sys_buf), .rst_sync (rst_sync), .fire (1'b0),
        .trigger_delayed_out (1'b0),
        .resp_data (resp_data), .resp_valid (resp_valid), .resp_ready (resp_ready)
    );

    always #50 clk_sys_buf = ~clk_sys_buf;

    always @(posedge clk_sys_buf) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("tests failed");
            $fatal(1, "timeout, simulation did not finish");
        end
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    function automatic logic [31:0] rand_next();
        rng_state = rng_state ^ (rng_state << 13);   // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                         input string what);
        if (expected !== actual) begin
            $display("FAILED at %0t: %s, expected 0x%0h, got 0x%0h",
                     $time, what, expected, actual);
            $display("tests failed");
            $fatal(1, "check mismatch");
        end
    endtask

    task automatic send_byte(input logic [BYTE_W-1:0] value);
        cmd_data  = value;
        cmd_valid = 1'b1;
        @(negedge clk_sys_buf);
        cmd_valid = 1'b0;   // Taken at the edge just passed
    endtask

    // Host side of the response handshake with random stalls
    task automatic recv_byte(output logic [BYTE_W-1:0] value);
        logic done;
        done = 1'b0;
        while (!done) begin
            resp_ready = (rand_next() % 4) != 0;
            if (resp_valid && resp_ready) begin
                value = resp_data;
                done  = 1'b1;
            end
            @(negedge clk_sys_buf);
        end
        resp_ready = 1'b0;
    endtask

    // Send a command with its payload and update the model
    task automatic configure(input cmd_code_e cmd, input logic [31:0] value);
        int i;
        send_byte(cmd);
        case (cmd)
            SET_DELAY, SET_WIDTH: begin
                for (i = 0; i < PAYLOAD_BYTES; i++) begin
                    send_byte(value[8*i +: 8]);
                end
            end
            SET_TRIG_MODE, SET_ARMED_MODE: send_byte(value[7:0]);
            default: ;
        endcase
        case (cmd)
            SET_DELAY:      delay_m = value;
            SET_WIDTH:      width_m = value;
            SET_TRIG_MODE:  trig_mode_m = trig_mode_e'(value[0]);
            SET_ARMED_MODE: armed_mode_m = armed_mode_e'(value[0]);
            ARM:            armed_m = 1'b1;
            DISARM:         armed_m = 1'b0;
            default: ;
        endcase
        if (cmd == ARM || cmd == DISARM) begin
            @(negedge clk_sys_buf);   // Armed flag follows the strobe one edge later
        end
    endtask

    task automatic read_value(input cmd_code_e cmd, input logic [31:0] expected,
                              input int nbytes);
        logic [BYTE_W-1:0] value;
        int                i;
        send_byte(cmd);
        for (i = 0; i < nbytes; i++) begin
            recv_byte(value);
            check(32'(expected[8*i +: 8]), 32'(value), $sformatf("%s byte %0d", cmd.name(), i));
        end
        check(32'd0, 32'(resp_valid), "response longer than expected");
    endtask

    task automatic expect_pulse(input int rise_edge, input int pulse_w);
        int w;
        while (!trigger_delayed_out && cycle < rise_edge + 2) begin
            @(negedge clk_sys_buf);
        end
        check(32'd1, 32'(trigger_delayed_out), "output pulse missing");
        check(32'(rise_edge), 32'(cycle), "output rise edge");
        w = 0;
        while (trigger_delayed_out && w <= pulse_w) begin
            w++;
            @(negedge clk_sys_buf);
        end
        check(32'(pulse_w), 32'(w), "output pulse width");
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            check(32'd0, 32'(trigger_delayed_out), "output pulse without an armed trigger");
            @(negedge clk_sys_buf);
        end
    endtask

    // Trigger from the selected source, then check against the model
    task automatic trigger_and_check();
        int   rise_edge;
        int   pulse_w;
        logic will_fire;
        will_fire = armed_m;
        pulse_w   = (width_m == 0) ? 1 : int'(width_m);
        if (trig_mode_m == SOFT) begin
            send_byte(SOFT_TRIGGER);
            rise_edge = cycle + int'(delay_m) + 2;
        end else begin
            trigger_in = 1'b1;
            @(negedge clk_sys_buf);
            rise_edge = cycle + int'(delay_m) + 5;   // From the first sampling edge
            repeat (3) @(negedge clk_sys_buf);
            trigger_in = 1'b0;
        end
        if (will_fire) begin
            expect_pulse(rise_edge, pulse_w);
            if (armed_mode_m == SINGLE) begin
                armed_m = 1'b0;
            end
        end else begin
            expect_quiet(int'(delay_m) + int'(width_m) + 10);
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        int n;
        clk_sys_buf  = 1'b0;
        rst_sync     = 1'b1;
        trigger_in   = 1'b0;
        cmd_data     = '0;
        cmd_valid    = 1'b0;
        resp_ready   = 1'b0;
        delay_m      = 32'(DEFAULT_DELAY);
        width_m      = 32'(DEFAULT_WIDTH);
        armed_m      = 1'b0;
        trig_mode_m  = EXTERNAL;
        armed_mode_m = SINGLE;
        repeat (8) @(negedge clk_sys_buf);
        rst_sync = 1'b0;

        // Reset state and no output while unarmed
        read_value(GET_DELAY, delay_m, 4);
        read_value(GET_WIDTH, width_m, 4);
        read_value(GET_ARMED, 32'(armed_m), 1);
        trigger_and_check();
        configure(SET_TRIG_MODE, 32'(SOFT));
        trigger_and_check();

        for (n = 0; n < N_READBACK; n++) begin   // Readback under back-pressure
            configure(SET_DELAY, rand_next());
            configure(SET_WIDTH, rand_next());
            read_value(GET_DELAY, delay_m, 4);
            read_value(GET_WIDTH, width_m, 4);
        end

        configure(SET_ARMED_MODE, 32'(REPEAT));
        configure(ARM, 32'd0);
        for (n = 0; n < 2 * N_TIMING; n++) begin
            if (n == N_TIMING) begin
                configure(SET_TRIG_MODE, 32'(EXTERNAL));   // Second half external
            end
            configure(SET_DELAY, rand_next() % 41);
            configure(SET_WIDTH, rand_next() % 21);
            trigger_and_check();
        end
        read_value(GET_ARMED, 32'(armed_m), 1);

        // Single shot where the second trigger stays quiet
        for (n = 0; n < N_SINGLE; n++) begin
            configure(SET_TRIG_MODE, rand_next() % 2);
            configure(SET_ARMED_MODE, 32'(SINGLE));
            configure(ARM, 32'd0);
            configure(SET_DELAY, rand_next() % 41);
            configure(SET_WIDTH, rand_next() % 21);
            trigger_and_check();
            read_value(GET_ARMED, 32'(armed_m), 1);
            trigger_and_check();
        end

        configure(SET_ARMED_MODE, 32'(REPEAT));
        configure(ARM, 32'd0);
        read_value(GET_ARMED, 32'(armed_m), 1);
        configure(DISARM, 32'd0);
        read_value(GET_ARMED, 32'(armed_m), 1);
        configure(SET_DELAY, rand_next() % 41);
        configure(SET_WIDTH, rand_next() % 21);
        configure(SET_TRIG_MODE, 32'(SOFT));
        trigger_and_check();
        configure(SET_TRIG_MODE, 32'(EXTERNAL));
        trigger_and_check();
        configure(ARM, 32'd0);
        read_value(GET_ARMED, 32'(armed_m), 1);

        $display("all tests passed");
        $finish;
    end

endmodule

/* verification/tb_trig_delay_asserts.sv */
module tb_trig_delay_asserts (
    input logic       clk_sys_buf,
    input logic       rst_sync,
    input logic       fire,
    input logic       trigger_delayed_out,
    input logic [7:0] resp_data,
    input logic       resp_valid,
    input logic       resp_ready
);

    timeunit 1ns;
    timeprecision 1ns;

    logic fire_pending;   // Fire seen, pulse not started yet

    always_ff @(posedge clk_sys_buf) begin
        if (rst_sync) begin
            fire_pending <= 1'b0;
        end else if (fire) begin
            fire_pending <= 1'b1;
        end else if (trigger_delayed_out) begin
            fire_pending <= 1'b0;
        end
    end

    rise_after_fire: assert property (@(posedge clk_sys_buf) disable iff (rst_sync)
        $rose(trigger_delayed_out) |-> fire_pending)
        else $error("output rose without a preceding fire");

    // Response byte held while the host stalls
    resp_stable: assert property (@(posedge clk_sys_buf) disable iff (rst_sync)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_data)))
        else $error("resp_data changed while waiting for resp_ready");

    resp_idle_after_reset: assert property (@(posedge clk_sys_buf)
        rst_sync |=> !resp_valid)
        else $error("resp_valid high after reset");

endmodule

/* rtl/trig_delay_top.sv */
module trig_delay_top import trig_delay_pkg::*; #(
    parameter int DELAY_W     = CFG_W,
    parameter int SYNC_STAGES = 3
) (
    input  logic              clk_sys_buf,
    input  logic              rst_sync,
    input  logic              trigger_in,
    input  logic [BYTE_W-1:0] cmd_data,
    input  logic              cmd_valid,
    output logic [BYTE_W-1:0] resp_data,
    output logic              resp_valid,
    input  logic              resp_ready,
    output logic              trigger_delayed_out
);

    logic edge_pulse;   // Synchronized rising edge of trigger_in
    logic fire;         // Armed and selected trigger

    trig_cfg_if #(.DELAY_W(DELAY_W)) cfg_bus ();

    // ========================================================================
    // Host command side
    // ========================================================================
    cmd_fsm #(
        .DELAY_W     (DELAY_W)
    ) cmd_fsm_i (
        .clk_sys_buf (clk_sys_buf),
        .rst_sync    (rst_sync),
        .cmd_data    (cmd_data),
        .cmd_valid   (cmd_valid),
        .resp_data   (resp_data),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .cfg         (cfg_bus.cfg_src)
    );

    // ========================================================================
    // Trigger path
    // ========================================================================
    trigger_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) trigger_sync_i (
        .clk_sys_buf (clk_sys_buf),
        .rst_sync    (rst_sync),
        .trigger_in  (trigger_in),
        .edge_pulse  (edge_pulse)
    );

    arm_control arm_control_i (
        .clk_sys_buf (clk_sys_buf),
        .rst_sync    (rst_sync),
        .edge_pulse  (edge_pulse),
        .cfg         (cfg_bus.cfg_dst),
        .fire        (fire)
    );

    delay_timer #(
        .DELAY_W             (DELAY_W)
    ) delay_timer_i (
        .clk_sys_buf         (clk_sys_buf),
        .rst_sync            (rst_sync),
        .fire                (fire),
        .delay               (cfg_bus.delay),
        .width               (cfg_bus.width),
        .trigger_delayed_out (trigger_delayed_out)
    );

endmodule

/* rtl/delay_timer.sv */
module delay_timer import trig_delay_pkg::*; #(
    parameter int DELAY_W = CFG_W
) (
    input  logic               clk_sys_buf,
    input  logic               rst_sync,
    input  logic               fire,
    input  logic [DELAY_W-1:0] delay,
    input  logic [DELAY_W-1:0] width,
    output logic               trigger_delayed_out
);

    typedef enum logic [1:0] {
        ST_IDLE,    // Waiting for fire
        ST_DELAY,   // Counting down the delay
        ST_PULSE    // Output high
    } state_e;

    state_e             state;
    logic [DELAY_W-1:0] delay_cnt;
    logic [DELAY_W-1:0] width_cnt;   // Remaining pulse cycles minus one

    // ========================================================================
    // Phase control
    // ========================================================================
    // Fire at edge k: pulse starts at edge k+delay+1
    always_ff @(posedge clk_sys_buf) begin
        if (rst_sync) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (fire) begin
                        state <= ST_DELAY;
                    end
                end
                ST_DELAY: begin
                    if (delay_cnt == '0) begin
                        state <= ST_PULSE;
                    end
                end
                ST_PULSE: begin
                    if (width_cnt == '0) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Counters are loaded on fire, so a later config write leaves this pulse alone
    always_ff @(posedge clk_sys_buf) begin
        case (state)
            ST_IDLE: begin
                if (fire) begin
                    delay_cnt <= delay;
                    width_cnt <= (width == '0) ? '0 : width - 1'b1;   // Width 0 acts as 1
                end
            end
            ST_DELAY: delay_cnt <= delay_cnt - 1'b1;
            ST_PULSE: width_cnt <= width_cnt - 1'b1;
            default:  delay_cnt <= delay_cnt;
        endcase
    end

    assign trigger_delayed_out = (state == ST_PULSE);

endmodule

/* rtl/arm_control.sv */
module arm_control import trig_delay_pkg::*; (
    input  logic        clk_sys_buf,
    input  logic        rst_sync,
    input  logic        edge_pulse,
    trig_cfg_if.cfg_dst cfg,
    output logic        fire
);

    logic armed_q;
    logic trig_sel;   // Selected source before the arm gate

    // ========================================================================
    // Source select and arm gate
    // ========================================================================
    assign trig_sel = (cfg.trig_mode == SOFT) ? cfg.soft_trigger : edge_pulse;
    assign fire     = trig_sel & armed_q;

    // ========================================================================
    // Armed flag
    // ========================================================================
    always_ff @(posedge clk_sys_buf) begin
        if (rst_sync) begin
            armed_q <= 1'b0;
        end else begin
            if (cfg.disarm) begin
                armed_q <= 1'b0;
            end else if (cfg.arm) begin
                armed_q <= 1'b1;
            end else if (fire && cfg.armed_mode == SINGLE) begin
                armed_q <= 1'b0;   // One shot used up
            end
        end
    end

    assign cfg.armed = armed_q;

endmodule

/* rtl/trigger_sync.sv */
module trigger_sync import trig_delay_pkg::*; #(
    parameter int SYNC_STAGES = 3
) (
    input  logic clk_sys_buf,
    input  logic rst_sync,
    input  logic trigger_in,
    output logic edge_pulse
);

    logic [SYNC_STAGES-1:0] sync_q;   // Bit 0 samples the pin
    logic                   hist_q;   // Previous synchronized value
    logic                   sync_bit;

    assign sync_bit = sync_q[SYNC_STAGES-1];

    // Synchronizer chain and edge history
    always_ff @(posedge clk_sys_buf) begin
        if (rst_sync) begin
            sync_q <= '0;
            hist_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], trigger_in};
            hist_q <= sync_bit;
        end
    end

    // Registered rising-edge compare, one cycle wide
    always_ff @(posedge clk_sys_buf) begin
        if (rst_sync) begin
            edge_pulse <= 1'b0;
        end else begin
            edge_pulse <= sync_bit & ~hist_q;
        end
    end

endmodule

/* cmd_fsm/cmd_fsm.sv */
module cmd_fsm import trig_delay_pkg::*; #(
    parameter int DELAY_W = CFG_W
) (
    input  logic              clk_sys_buf,
    input  logic              rst_sync,
    input  logic [BYTE_W-1:0] cmd_data,
    input  logic              cmd_valid,
    output logic [BYTE_W-1:0] resp_data,
    output logic              resp_valid,
    input  logic              resp_ready,
    trig_cfg_if.cfg_src       cfg
);

    typedef enum logic [1:0] {
        ST_IDLE,      // Wait for a command byte
        ST_PAYLOAD,   // Collect a 4-byte value
        ST_BYTE,      // Collect a 1-byte mode value
        ST_RESP       // Send response bytes
    } state_e;

    state_e             state;
    cmd_code_e          cmd_in;
    cmd_code_e          cmd_q;          // Command that owns the current payload
    logic [IDX_W-1:0]   byte_idx;       // Payload or response byte, LSB first
    logic [IDX_W-1:0]   resp_last;      // Index of the final response byte
    logic [PAYLOAD_W-1:0] payload_q;
    logic [PAYLOAD_W-1:0] payload_next;
    logic [PAYLOAD_W-1:0] resp_q;       // Response shift register

    // Configuration registers
    logic [DELAY_W-1:0] delay_q;
    logic [DELAY_W-1:0] width_q;
    trig_mode_e         trig_mode_q;
    armed_mode_e        armed_mode_q;
    logic               soft_q;
    logic               arm_q;
    logic               disarm_q;

    assign cmd_in       = cmd_code_e'(cmd_data);
    assign payload_next = {cmd_data, payload_q[PAYLOAD_W-1:BYTE_W]};  // Shift in at the top

    // ========================================================================
    // Control and configuration
    // ========================================================================
    always_ff @(posedge clk_sys_buf) begin
        if (rst_sync) begin
            state        <= ST_IDLE;
            byte_idx     <= '0;
            delay_q      <= DELAY_W'(DEFAULT_DELAY);
            width_q      <= DELAY_W'(DEFAULT_WIDTH);
            trig_mode_q  <= EXTERNAL;
            armed_mode_q <= SINGLE;
            soft_q       <= 1'b0;
            arm_q        <= 1'b0;
            disarm_q     <= 1'b0;
        end else begin
            soft_q   <= 1'b0;   // Strobes last one cycle
            arm_q    <= 1'b0;
            disarm_q <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        byte_idx <= '0;
                        case (cmd_in)
                            SET_DELAY, SET_WIDTH:            state <= ST_PAYLOAD;
                            SET_TRIG_MODE, SET_ARMED_MODE:   state <= ST_BYTE;
                            GET_DELAY, GET_WIDTH, GET_ARMED: state <= ST_RESP;
                            SOFT_TRIGGER:                    soft_q <= 1'b1;
                            ARM:                             arm_q <= 1'b1;
                            DISARM:                          disarm_q <= 1'b1;
                            default:                         state <= ST_IDLE;
                        endcase
                    end
                end

                ST_PAYLOAD: begin
                    if (cmd_valid) begin
                        byte_idx <= byte_idx + 1'b1;
                        // Last byte writes the register on the same edge
                        if (byte_idx == IDX_W'(PAYLOAD_BYTES - 1)) begin
                            if (cmd_q == SET_DELAY) begin
                                delay_q <= DELAY_W'(payload_next);
                            end else begin
                                width_q <= DELAY_W'(payload_next);
                            end
                            state <= ST_IDLE;
                        end
                    end
                end

                ST_BYTE: begin
                    if (cmd_valid) begin
                        if (cmd_q == SET_TRIG_MODE) begin
                            trig_mode_q <= trig_mode_e'(cmd_data[0]);
                        end else begin
                            armed_mode_q <= armed_mode_e'(cmd_data[0]);
                        end
                        state <= ST_IDLE;
                    end
                end

                ST_RESP: begin
                    if (resp_ready) begin   // resp_valid is high in this state
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == resp_last) begin
                            state <= ST_IDLE;
                        end
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // ========================================================================
    // Payload and response data
    // ========================================================================
    always_ff @(posedge clk_sys_buf) begin
        if (state == ST_IDLE && cmd_valid) begin
            cmd_q     <= cmd_in;
            resp_last <= IDX_W'(PAYLOAD_BYTES - 1);
            case (cmd_in)
                GET_DELAY: resp_q <= PAYLOAD_W'(delay_q);
                GET_WIDTH: resp_q <= PAYLOAD_W'(width_q);
                GET_ARMED: begin
                    resp_q    <= PAYLOAD_W'(cfg.armed);
                    resp_last <= '0;   // Single byte
                end
                default: resp_q <= resp_q;
            endcase
        end

        if (state == ST_PAYLOAD && cmd_valid) begin
            payload_q <= payload_next;
        end

        if (resp_valid && resp_ready) begin
            resp_q <= resp_q >> BYTE_W;   // Next byte moves to the bottom
        end
    end

    assign resp_valid = (state == ST_RESP);
    assign resp_data  = resp_q[BYTE_W-1:0];   // Held until the handshake

    assign cfg.delay        = delay_q;
    assign cfg.width        = width_q;
    assign cfg.trig_mode    = trig_mode_q;
    assign cfg.armed_mode   = armed_mode_q;
    assign cfg.soft_trigger = soft_q;
    assign cfg.arm          = arm_q;
    assign cfg.disarm       = disarm_q;

endmodule

/* common/trig_cfg_if.sv */
interface trig_cfg_if import trig_delay_pkg::*; #(
    parameter int DELAY_W = CFG_W
);

    logic [DELAY_W-1:0] delay;         // Cycles from fire to output rise
    logic [DELAY_W-1:0] width;         // Output pulse width, 0 acts as 1
    trig_mode_e         trig_mode;
    armed_mode_e        armed_mode;
    logic               soft_trigger;  // One-cycle strobes from the command FSM
    logic               arm;
    logic               disarm;
    logic               armed;         // Armed flag, read back by GET_ARMED

    // Command side, owns the configuration
    modport cfg_src (
        output delay, width, trig_mode, armed_mode,
        output soft_trigger, arm, disarm,
        input  armed
    );

    // Trigger path side
    modport cfg_dst (
        input  delay, width, trig_mode, armed_mode,
        input  soft_trigger, arm, disarm,
        output armed
    );

endinterface

/* common/trig_delay_pkg.sv */
package trig_delay_pkg;

    // ========================================================================
    // Widths
    // ========================================================================
    localparam int CFG_W         = 32;                     // Delay and width values
    localparam int BYTE_W        = 8;                      // Command and response bytes
    localparam int PAYLOAD_BYTES = 4;                      // 32-bit payload, LSB first
    localparam int PAYLOAD_W     = PAYLOAD_BYTES * BYTE_W;
    localparam int IDX_W         = $clog2(PAYLOAD_BYTES);  // Payload byte index

    // ========================================================================
    // Command codes
    // ========================================================================
    // Any byte not listed here is ignored in idle
    typedef enum logic [7:0] {
        SET_DELAY      = 8'h01,
        GET_DELAY      = 8'h02,
        SET_WIDTH      = 8'h03,
        GET_WIDTH      = 8'h04,
        SET_TRIG_MODE  = 8'h05,
        SOFT_TRIGGER   = 8'h06,
        ARM            = 8'h07,
        DISARM         = 8'h08,
        SET_ARMED_MODE = 8'h09,
        GET_ARMED      = 8'h0A
    } cmd_code_e;

    // Trigger source select
    typedef enum logic {
        EXTERNAL = 1'b0,
        SOFT     = 1'b1
    } trig_mode_e;

    // Behavior of the armed flag after a fire
    typedef enum logic {
        SINGLE = 1'b0,   // Disarm after one fire
        REPEAT = 1'b1    // Stay armed
    } armed_mode_e;

    // ========================================================================
    // Reset defaults
    // ========================================================================
    localparam int DEFAULT_DELAY = 0;
    localparam int DEFAULT_WIDTH = 1;

endpackage
